//--- build.f
+incdir+.
isaPkg.sv
corePkg.sv
controlUnit.sv
programCounter.sv
registerFile.sv
aluUnit.sv
busPort.sv
mipsCore.sv
tbWishboneMemory.sv
tbMipsCore.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tbMipsCore
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tbMipsCore.sv
`timescale 1ns/100ps
`default_nettype none

`include "mipsCore_params.svh"

module tbMipsCore import corePkg::*, isaPkg::*; ();

    localparam logic [31:0] HaltAddr = 32'h0000_00f0;
    localparam logic [31:0] DataBase = 32'h0000_0200;

    logic       clock;
    logic       reset;
    logic       randomDelay;
    wbRequestT  wbReq;
    wbResponseT wbResp;

    logic [31:0] image [1024];
    logic [31:0] refMem [1024];
    logic [31:0] refRegs [32];
    logic [31:0] expFetch [$];
    logic [31:0] expStoreAdr [$];
    logic [31:0] expStoreDat [$];
    int fetchIndex;
    int storeIndex;
    int testErrors;
    int testsRun;
    int testsFailed;
    bit checking;
    bit halted;

    mipsCore mipsCore_i (.clock(clock), .reset(reset), .wbResp(wbResp), .wbReq(wbReq));

    tbWishboneMemory memory_i (
        .clock(clock), .reset(reset), .randomDelay(randomDelay),
        .wbReq(wbReq), .wbResp(wbResp)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    function automatic logic [31:0] encR(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
                                         logic [5:0] fn);
        return {6'h00, rs, rt, rd, 5'h00, fn};
    endfunction

    function automatic logic [31:0] encI(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                         logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encJ(logic [5:0] op, logic [31:0] addr);
        return {op, addr[27:2]};
    endfunction

    task automatic put(input logic [31:0] addr, input logic [31:0] word);
        image[addr[11:2]] = word;
    endtask

    // Fill pattern, trap handlers and the halt loop
    task automatic clearImage();
        for (int i = 0; i < 1024; i++) begin
            image[i] = (i * 32'h9e37_79b1) ^ {i[15:0], ~i[15:0]};
        end
        put(`OVERFLOW_VECTOR, encI(opSw, 0, 3, 16'h0220));
        put(`OVERFLOW_VECTOR + 4, encJ(opJ, HaltAddr));
        put(`OPCODE_VECTOR, encJ(opJ, HaltAddr));
        put(HaltAddr, encJ(opJ, HaltAddr));
    endtask

    function automatic void writeReg(logic [4:0] idx, logic [31:0] value);
        if (idx != 0) begin
            refRegs[idx] = value;
        end
    endfunction

    // Instruction-level model of the subset
    function automatic void runReference();
        logic [31:0] pc, ins, a, b, simm, res, next, addr;
        logic [5:0]  op, fn;
        pc = `RESET_PC;
        expFetch.delete();
        expStoreAdr.delete();
        expStoreDat.delete();
        for (int i = 0; i < 32; i++) refRegs[i] = '0;
        for (int i = 0; i < 1024; i++) refMem[i] = image[i];
        for (int step = 0; step < 500; step++) begin
            expFetch.push_back(pc);
            if (pc == HaltAddr) break;
            ins  = refMem[pc[11:2]];
            op   = ins[31:26];
            fn   = ins[5:0];
            a    = refRegs[ins[25:21]];
            b    = refRegs[ins[20:16]];
            simm = {{16{ins[15]}}, ins[15:0]};
            addr = a + simm;
            next = pc + 4;
            case (op)
                6'h00: begin
                    case (fn)
                        6'h20: begin
                            res = a + b;
                            if (a[31] == b[31] && res[31] != a[31]) next = `OVERFLOW_VECTOR;
                            else writeReg(ins[15:11], res);
                        end
                        6'h22: begin
                            res = a - b;
                            if (a[31] != b[31] && res[31] != a[31]) next = `OVERFLOW_VECTOR;
                            else writeReg(ins[15:11], res);
                        end
                        6'h24: writeReg(ins[15:11], a & b);
                        6'h2a: writeReg(ins[15:11], {31'b0, $signed(a) < $signed(b)});
                        6'h08: next = a;
                        default: next = `OPCODE_VECTOR;
                    endcase
                end
                6'h08: begin
                    res = a + simm;
                    if (a[31] == simm[31] && res[31] != a[31]) next = `OVERFLOW_VECTOR;
                    else writeReg(ins[20:16], res);
                end
                6'h09: writeReg(ins[20:16], a + simm);
                6'h0a: writeReg(ins[20:16], {31'b0, $signed(a) < $signed(simm)});
                6'h04: if (a == b) next = pc + 4 + (simm << 2);
                6'h05: if (a != b) next = pc + 4 + (simm << 2);
                6'h23: writeReg(ins[20:16], refMem[addr[11:2]]);
                6'h2b: begin
                    refMem[addr[11:2]] = b;
                    expStoreAdr.push_back(addr);
                    expStoreDat.push_back(b);
                end
                6'h02: next = {next[31:28], ins[25:0], 2'b00};
                6'h03: begin
                    refRegs[31] = pc + 4;
                    next = {next[31:28], ins[25:0], 2'b00};
                end
                default: next = `OPCODE_VECTOR;
            endcase
            pc = next;
        end
    endfunction

    task automatic reportValue(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
        testErrors++;
    endtask

    // Compares every acknowledged store and fetch against the model
    always @(posedge clock) begin
        if (checking && !halted && wbReq.cyc && wbReq.stb && wbResp.ack) begin
            if (wbReq.we) begin
                if (storeIndex >= expStoreAdr.size()) begin
                    $display("store to %h at %0t was not expected", wbReq.adr, $time);
                    testErrors++;
                end else begin
                    if (wbReq.adr !== expStoreAdr[storeIndex])
                        reportValue("wbReq.adr", expStoreAdr[storeIndex], wbReq.adr);
                    if (wbReq.dat !== expStoreDat[storeIndex])
                        reportValue("wbReq.dat", expStoreDat[storeIndex], wbReq.dat);
                end
                storeIndex++;
            end else if (wbReq.adr < DataBase) begin
                if (fetchIndex >= expFetch.size()) begin
                    $display("fetch from %h at %0t was not expected", wbReq.adr, $time);
                    testErrors++;
                end else if (wbReq.adr !== expFetch[fetchIndex]) begin
                    reportValue("fetch wbReq.adr", expFetch[fetchIndex], wbReq.adr);
                end
                fetchIndex++;
                if (wbReq.adr == HaltAddr) halted = 1'b1;
            end
        end
    end

    task automatic runTest(input string name, input logic delayed);
        int cycles;
        int limit;
        checking = 1'b0;
        halted   = 1'b0;
        for (int i = 0; i < 1024; i++) memory_i.words[i] = image[i];
        runReference();
        limit = 60 * expFetch.size();
        fetchIndex = 0;
        storeIndex = 0;
        testErrors = 0;
        @(posedge clock);
        reset       <= 1'b1;
        randomDelay <= delayed;
        for (int i = 0; i < 3; i++) begin
            @(posedge clock);
            if (i > 0 && (wbReq.cyc !== 1'b0 || wbReq.stb !== 1'b0)) begin
                $display("cyc or stb high during reset at %0t", $time);
                testErrors++;
            end
        end
        reset    <= 1'b0;
        checking = 1'b1;
        cycles   = 0;
        while (!halted && cycles < limit) begin
            @(posedge clock);
            cycles++;
        end
        checking = 1'b0;
        if (!halted) begin
            $display("%s did not reach the halt loop within %0d cycles", name, limit);
            testErrors++;
        end
        if (storeIndex != expStoreAdr.size()) begin
            $display("%s made %0d stores instead of %0d", name, storeIndex, expStoreAdr.size());
            testErrors++;
        end
        testsRun++;
        if (testErrors != 0) testsFailed++;
        $display("%s delay=%s: %s, %0d fetches, %0d stores", name,
                 delayed ? "random" : "zero", (testErrors == 0) ? "ok" : "FAILED",
                 fetchIndex, storeIndex);
    endtask

    task automatic runBoth(input string name);
        runTest(name, 1'b0);
        runTest(name, 1'b1);
    endtask

    initial begin
        reset       = 1'b1;
        randomDelay = 1'b0;
        checking    = 1'b0;
        halted      = 1'b0;
        testsRun    = 0;
        testsFailed = 0;

        clearImage();
        put(32'h00, encI(opAddi, 0, 1, 16'd5));
        put(32'h04, encI(opAddi, 0, 2, -16'sd3));
        put(32'h08, encR(1, 2, 3, fnAdd));
        put(32'h0c, encR(2, 1, 4, fnSub));
        put(32'h10, encR(1, 2, 5, fnAnd));
        put(32'h14, encR(2, 1, 6, fnSlt));
        put(32'h18, encI(opSlti, 1, 7, -16'sd1));
        put(32'h1c, encI(opAddiu, 2, 8, 16'd100));
        put(32'h20, encI(opAddi, 0, 0, 16'd7));
        for (int r = 3; r <= 8; r++) begin
            put(32'h24 + 4 * (r - 3), encI(opSw, 0, 5'(r), 16'(32'h200 + 4 * r)));
        end
        put(32'h3c, encI(opSw, 0, 0, 16'h0240));
        put(32'h40, encJ(opJ, HaltAddr));
        runBoth("arithmetic");

        clearImage();
        put(32'h300, 32'hcafe_f00d);
        put(32'h00, encI(opAddi, 0, 1, 16'h1234));
        put(32'h04, encI(opSw, 0, 1, 16'h0200));
        put(32'h08, encI(opLw, 0, 2, 16'h0200));
        put(32'h0c, encI(opSw, 0, 2, 16'h0204));
        put(32'h10, encI(opLw, 0, 3, 16'h0300));
        put(32'h14, encI(opSw, 0, 3, 16'h0208));
        put(32'h18, encJ(opJ, HaltAddr));
        runBoth("loadStore");

        clearImage();
        put(32'h00, encI(opAddi, 0, 1, 16'd1));
        put(32'h04, encI(opBeq, 1, 0, 16'd1));
        put(32'h08, encI(opSw, 0, 1, 16'h0200));
        put(32'h0c, encI(opBne, 1, 0, 16'd1));
        put(32'h10, encI(opSw, 0, 1, 16'h0204));
        put(32'h14, encJ(opJal, 32'h40));
        put(32'h18, encI(opSw, 0, 31, 16'h0208));
        put(32'h1c, encI(opBeq, 0, 0, 16'd1));
        put(32'h20, encI(opSw, 0, 1, 16'h020c));
        put(32'h24, encJ(opJ, HaltAddr));
        put(32'h40, encI(opAddi, 0, 2, 16'd7));
        put(32'h44, encI(opSw, 0, 2, 16'h0210));
        put(32'h48, encI(opBne, 0, 0, 16'd1));
        put(32'h4c, encR(31, 0, 0, fnJr));
        runBoth("controlFlow");

        // 0x7fffffff plus one overflows signed
        clearImage();
        put(32'h300, 32'h7fff_ffff);
        put(32'h00, encI(opAddi, 0, 3, 16'd9));
        put(32'h04, encI(opLw, 0, 1, 16'h0300));
        put(32'h08, encI(opAddiu, 1, 2, 16'd1));
        put(32'h0c, encI(opSw, 0, 2, 16'h0200));
        put(32'h10, encI(opAddi, 1, 3, 16'd1));
        put(32'h14, encI(opSw, 0, 3, 16'h0204));
        put(32'h18, encJ(opJ, HaltAddr));
        runBoth("overflowAddi");
        put(32'h10, encR(1, 1, 3, fnAdd));
        runBoth("overflowAdd");

        clearImage();
        put(32'h00, encI(opAddi, 0, 1, 16'd1));
        put(32'h04, encI(opSw, 0, 1, 16'h0200));
        put(32'h08, {6'h3f, 26'h0});
        put(32'h0c, encI(opSw, 0, 1, 16'h0204));
        put(32'h10, encJ(opJ, HaltAddr));
        runBoth("badOpcode");
        put(32'h08, encR(1, 1, 2, 6'h3f));
        runBoth("badFunct");

        $display("tests run %0d, passed %0d, failed %0d",
                 testsRun, testsRun - testsFailed, testsFailed);
        if (testsFailed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tbWishboneMemory.sv
`timescale 1ns/100ps
`default_nettype none

`include "mipsCore_params.svh"

module tbWishboneMemory import corePkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  logic       randomDelay,
    input  wbRequestT  wbReq,
    output wbResponseT wbResp
);

    logic [`DATA_WIDTH-1:0] words [1024];
    int                     waitCount;
    int                     seed = 32'h5e6978b5;

    // Cycles to hold off the next ack, 0 to 3 when random
    function int drawDelay();
        if (!randomDelay) begin
            return 0;
        end
        return int'($unsigned($random(seed)) % 4);
    endfunction

    always @(posedge clock) begin
        if (reset) begin
            wbResp.ack <= 1'b0;
            wbResp.dat <= '0;
            waitCount  <= drawDelay();
        end else if (wbResp.ack) begin
            wbResp.ack <= 1'b0;
            waitCount  <= drawDelay();
        end else if (wbReq.cyc && wbReq.stb) begin
            if (waitCount == 0) begin
                wbResp.ack <= 1'b1;
                if (wbReq.we) begin
                    words[wbReq.adr[11:2]] <= wbReq.dat;
                end else begin
                    wbResp.dat <= words[wbReq.adr[11:2]];
                end
            end else begin
                waitCount <= waitCount - 1;
            end
        end
    end

endmodule

`default_nettype wire

//--- mipsCore.sv
`timescale 1ns/100ps
`default_nettype none

`include "mipsCore_params.svh"

module mipsCore import corePkg::*, isaPkg::*; (
    input  logic       clock,
    input  logic       reset,
    input  wbResponseT wbResp,
    output wbRequestT  wbReq
);

    controlWordT            control;
    instrT                  instr;
    logic                   memDone;
    logic                   zero;
    logic                   overflow;
    logic [`DATA_WIDTH-1:0] pc;
    logic [`DATA_WIDTH-1:0] aluResult;
    logic [`DATA_WIDTH-1:0] aluOut;
    logic [`DATA_WIDTH-1:0] regA;
    logic [`DATA_WIDTH-1:0] regB;
    logic [`DATA_WIDTH-1:0] memData;

    controlUnit controlUnit_i (
        .clock(clock), .reset(reset), .instr(instr), .memDone(memDone),
        .zero(zero), .overflow(overflow), .control(control)
    );

    programCounter programCounter_i (
        .clock(clock), .reset(reset), .control(control), .aluResult(aluResult),
        .aluOut(aluOut), .regA(regA), .instr(instr), .pc(pc)
    );

    registerFile registerFile_i (
        .clock(clock), .reset(reset), .control(control), .instr(instr),
        .aluOut(aluOut), .memData(memData), .pc(pc), .regA(regA), .regB(regB)
    );

    aluUnit aluUnit_i (
        .clock(clock), .reset(reset), .control(control), .pc(pc), .regA(regA),
        .regB(regB), .instr(instr), .aluResult(aluResult), .aluOut(aluOut),
        .zero(zero), .overflow(overflow)
    );

    // Sole path to memory for fetches, loads and stores
    busPort busPort_i (
        .clock(clock), .reset(reset), .control(control), .pc(pc), .aluOut(aluOut),
        .regB(regB), .wbResp(wbResp), .wbReq(wbReq), .instr(instr),
        .memData(memData), .memDone(memDone)
    );

endmodule

`default_nettype wire

//--- busPort.sv
`timescale 1ns/100ps
`default_nettype none

`include "mipsCore_params.svh"

module busPort import corePkg::*, isaPkg::*; (
    input  logic                   clock,
    input  logic                   reset,
    input  controlWordT            control,
    input  logic [`DATA_WIDTH-1:0] pc,
    input  logic [`DATA_WIDTH-1:0] aluOut,
    input  logic [`DATA_WIDTH-1:0] regB,
    input  wbResponseT             wbResp,
    output wbRequestT              wbReq,
    output instrT                  instr,
    output logic [`DATA_WIDTH-1:0] memData,
    output logic                   memDone
);

    logic idleCycle;
    logic active;

    // Cycle drops for one clock after every ack, also straight out of reset
    assign active = control.memRequest && !idleCycle;

    always_comb begin
        wbReq.cyc = active;
        wbReq.stb = active;
        wbReq.we  = active && control.memWrite;
        wbReq.adr = control.memUsesAlu ? aluOut : pc;
        wbReq.dat = regB;
    end

    assign memDone = active && wbResp.ack;

    always_ff @(posedge clock) begin
        if (reset) begin
            idleCycle <= 1'b1;
        end else begin
            idleCycle <= memDone;
        end
    end

    // Read data lands in the IR on fetch, in MDR otherwise
    always_ff @(posedge clock) begin
        if (memDone) begin
            if (control.irWrite) begin
                instr <= instrT'(wbResp.dat);
            end else begin
                memData <= wbResp.dat;
            end
        end
    end

endmodule

`default_nettype wire

//--- aluUnit.sv
`timescale 1ns/100ps
`default_nettype none

`include "mipsCore_params.svh"

module aluUnit import corePkg::*, isaPkg::*; (
    input  logic                   clock,
    input  logic                   reset,
    input  controlWordT            control,
    input  logic [`DATA_WIDTH-1:0] pc,
    input  logic [`DATA_WIDTH-1:0] regA,
    input  logic [`DATA_WIDTH-1:0] regB,
    input  instrT                  instr,
    output logic [`DATA_WIDTH-1:0] aluResult,
    output logic [`DATA_WIDTH-1:0] aluOut,
    output logic                   zero,
    output logic                   overflow
);

    localparam int Msb = `DATA_WIDTH - 1;

    logic [`DATA_WIDTH-1:0] operandA;
    logic [`DATA_WIDTH-1:0] operandB;
    logic [`DATA_WIDTH-1:0] signImm;
    logic [`DATA_WIDTH-1:0] branchOffset;
    logic [15:0]            imm;

    assign imm          = instr.body.f.low.imm;
    assign signImm      = {{(`DATA_WIDTH - 16){imm[15]}}, imm};
    assign branchOffset = {signImm[`DATA_WIDTH-3:0], 2'b00};

    assign operandA = (control.aluSrcA == srcAPc) ? pc : regA;

    always_comb begin
        case (control.aluSrcB)
            srcBRegB:         operandB = regB;
            srcBFour:         operandB = `DATA_WIDTH'(4);
            srcBBranchOffset: operandB = branchOffset;
            default:          operandB = signImm;
        endcase
    end

    always_comb begin
        overflow = 1'b0;
        case (control.aluOp)
            aluAdd: begin
                aluResult = operandA + operandB;
                overflow  = (operandA[Msb] == operandB[Msb]) && (aluResult[Msb] != operandA[Msb]);
            end
            aluSub: begin
                aluResult = operandA - operandB;
                overflow  = (operandA[Msb] != operandB[Msb]) && (aluResult[Msb] != operandA[Msb]);
            end
            aluAnd:     aluResult = operandA & operandB;
            aluSetLess: aluResult = `DATA_WIDTH'($signed(operandA) < $signed(operandB));
            default:    aluResult = operandA;
        endcase
    end

    assign zero = (aluResult == '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            aluOut <= '0;
        end else begin
            aluOut <= aluResult;
        end
    end

endmodule

`default_nettype wire

//--- registerFile.sv
`timescale 1ns/100ps
`default_nettype none

`include "mipsCore_params.svh"

module registerFile import corePkg::*, isaPkg::*; (
    input  logic                   clock,
    input  logic                   reset,
    input  controlWordT            control,
    input  instrT                  instr,
    input  logic [`DATA_WIDTH-1:0] aluOut,
    input  logic [`DATA_WIDTH-1:0] memData,
    input  logic [`DATA_WIDTH-1:0] pc,
    output logic [`DATA_WIDTH-1:0] regA,
    output logic [`DATA_WIDTH-1:0] regB
);

    logic [`DATA_WIDTH-1:0]     regs [`REG_COUNT];
    logic [`REG_ADDR_WIDTH-1:0] rsIndex;
    logic [`REG_ADDR_WIDTH-1:0] rtIndex;
    logic [`REG_ADDR_WIDTH-1:0] destIndex;
    logic [`DATA_WIDTH-1:0]     writeData;

    assign rsIndex = instr.body.f.rs;
    assign rtIndex = instr.body.f.rt;

    always_comb begin
        case (control.regDst)
            dstRd:   destIndex = instr.body.f.low.r.rd;
            dstLink: destIndex = `REG_ADDR_WIDTH'(`LINK_REG);
            default: destIndex = rtIndex;
        endcase
        case (control.writeSource)
            wsMemData: writeData = memData;
            wsPc:      writeData = pc;
            default:   writeData = aluOut;
        endcase
    end

    // Register 0 is never written
    always_ff @(posedge clock) begin
        if (control.regWrite && destIndex != '0) begin
            regs[destIndex] <= writeData;
        end
    end

    // A and B follow the IR fields every cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            regA <= '0;
            regB <= '0;
        end else begin
            regA <= (rsIndex == '0) ? '0 : regs[rsIndex];
            regB <= (rtIndex == '0) ? '0 : regs[rtIndex];
        end
    end

endmodule

`default_nettype wire

//--- programCounter.sv
`timescale 1ns/100ps
`default_nettype none

`include "mipsCore_params.svh"

module programCounter import corePkg::*, isaPkg::*; (
    input  logic                   clock,
    input  logic                   reset,
    input  controlWordT            control,
    input  logic [`DATA_WIDTH-1:0] aluResult,
    input  logic [`DATA_WIDTH-1:0] aluOut,
    input  logic [`DATA_WIDTH-1:0] regA,
    input  instrT                  instr,
    output logic [`DATA_WIDTH-1:0] pc
);

    logic [`DATA_WIDTH-1:0] nextPc;
    logic [`DATA_WIDTH-1:0] jumpTarget;

    // Region bits come from the already incremented PC
    assign jumpTarget = {pc[`DATA_WIDTH-1:28], instr.body.target, 2'b00};

    always_comb begin
        case (control.pcSource)
            pcAluOut:         nextPc = aluOut;
            pcJumpTarget:     nextPc = jumpTarget;
            pcRegA:           nextPc = regA;
            pcOverflowVector: nextPc = `OVERFLOW_VECTOR;
            pcOpcodeVector:   nextPc = `OPCODE_VECTOR;
            default:          nextPc = aluResult;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= `RESET_PC;
        end else if (control.pcWrite) begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

//--- controlUnit.sv
`timescale 1ns/100ps
`default_nettype none

module controlUnit import corePkg::*, isaPkg::*; (
    input  logic        clock,
    input  logic        reset,
    input  instrT       instr,
    input  logic        memDone,
    input  logic        zero,
    input  logic        overflow,
    output controlWordT control
);

    stateT  state;
    stateT  nextState;
    stateT  decodeTarget;
    opcodeT opcode;
    functT  funct;
    aluOpT  rTypeOp;

    assign opcode = instr.opcode;
    assign funct  = instr.body.f.low.r.funct;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= stFetch;
        end else begin
            state <= nextState;
        end
    end

    // Dispatch from decode, anything unrecognised traps
    always_comb begin
        case (opcode)
            opRType: begin
                case (funct)
                    fnAdd, fnSub, fnAnd, fnSlt: decodeTarget = stExecuteR;
                    fnJr:                       decodeTarget = stJumpReg;
                    default:                    decodeTarget = stOpcodeTrap;
                endcase
            end
            opAddi, opAddiu, opSlti: decodeTarget = stExecuteI;
            opBeq, opBne:            decodeTarget = stBranch;
            opLw, opSw:              decodeTarget = stMemAddress;
            opJ:                     decodeTarget = stJump;
            opJal:                   decodeTarget = stJumpLink;
            default:                 decodeTarget = stOpcodeTrap;
        endcase
    end

    always_comb begin
        case (funct)
            fnSub:   rTypeOp = aluSub;
            fnAnd:   rTypeOp = aluAnd;
            fnSlt:   rTypeOp = aluSetLess;
            default: rTypeOp = aluAdd;
        endcase
    end

    always_comb begin
        case (state)
            stFetch:      nextState = memDone ? stDecode : stFetch;
            stDecode:     nextState = decodeTarget;
            // Overflow diverts before the write-back cycle
            stExecuteR:   nextState = overflow ? stOverflowTrap : stWriteBack;
            stExecuteI:   nextState = (overflow && opcode == opAddi) ? stOverflowTrap
                                                                    : stWriteBack;
            stMemAddress: nextState = (opcode == opLw) ? stMemRead : stMemWrite;
            stMemRead:    nextState = memDone ? stLoadWriteBack : stMemRead;
            stMemWrite:   nextState = memDone ? stFetch : stMemWrite;
            stJumpLink:   nextState = stJump;
            default:      nextState = stFetch;
        endcase
    end

    always_comb begin
        control             = '0;
        control.pcSource    = pcIncrement;
        control.regDst      = dstRt;
        control.writeSource = wsAluOut;
        control.aluSrcA     = srcARegA;
        control.aluSrcB     = srcBSignImm;
        control.aluOp       = aluPassA;
        case (state)
            stFetch: begin
                // PC+4 from the ALU, taken together with the IR on ack
                control.memRequest = 1'b1;
                control.irWrite    = memDone;
                control.pcWrite    = memDone;
                control.aluSrcA    = srcAPc;
                control.aluSrcB    = srcBFour;
                control.aluOp      = aluAdd;
            end
            stDecode: begin
                // Branch target into ALUOut ahead of time
                control.aluSrcA = srcAPc;
                control.aluSrcB = srcBBranchOffset;
                control.aluOp   = aluAdd;
            end
            stExecuteR: begin
                control.aluSrcB = srcBRegB;
                control.aluOp   = rTypeOp;
            end
            stExecuteI: begin
                control.aluOp = (opcode == opSlti) ? aluSetLess : aluAdd;
            end
            stWriteBack: begin
                control.regWrite = 1'b1;
                control.regDst   = (opcode == opRType) ? dstRd : dstRt;
            end
            stMemAddress, stMemRead, stMemWrite: begin
                // Address recomputed each cycle so ALUOut holds during the wait
                control.aluOp      = aluAdd;
                control.memRequest = (state != stMemAddress);
                control.memUsesAlu = 1'b1;
                control.memWrite   = (state == stMemWrite);
            end
            stLoadWriteBack: begin
                control.regWrite    = 1'b1;
                control.writeSource = wsMemData;
            end
            stBranch: begin
                control.aluSrcB  = srcBRegB;
                control.aluOp    = aluSub;
                control.pcSource = pcAluOut;
                control.pcWrite  = (opcode == opBeq) ? zero : !zero;
            end
            stJump: begin
                control.pcWrite  = 1'b1;
                control.pcSource = pcJumpTarget;
            end
            stJumpLink: begin
                // PC already holds the return address
                control.regWrite    = 1'b1;
                control.regDst      = dstLink;
                control.writeSource = wsPc;
            end
            stJumpReg: begin
                control.pcWrite  = 1'b1;
                control.pcSource = pcRegA;
            end
            stOverflowTrap: begin
                control.pcWrite  = 1'b1;
                control.pcSource = pcOverflowVector;
            end
            stOpcodeTrap: begin
                control.pcWrite  = 1'b1;
                control.pcSource = pcOpcodeVector;
            end
            default: begin
                control.pcWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- corePkg.sv
`default_nettype none

`include "mipsCore_params.svh"

package corePkg;

    typedef enum logic [3:0] {
        stFetch, stDecode, stExecuteR, stExecuteI, stWriteBack,
        stMemAddress, stMemRead, stMemWrite, stLoadWriteBack,
        stBranch, stJump, stJumpLink, stJumpReg,
        stOverflowTrap, stOpcodeTrap
    } stateT;

    typedef enum logic [2:0] {
        aluAdd, aluSub, aluAnd, aluSetLess, aluPassA
    } aluOpT;

    typedef enum logic [2:0] {
        pcIncrement, pcAluOut, pcJumpTarget, pcRegA,
        pcOverflowVector, pcOpcodeVector
    } pcSourceT;

    typedef enum logic [1:0] {dstRt, dstRd, dstLink} regDstT;
    typedef enum logic [1:0] {wsAluOut, wsMemData, wsPc} writeSourceT;
    typedef enum logic {srcAPc, srcARegA} aluSrcAT;
    typedef enum logic [1:0] {srcBRegB, srcBFour, srcBSignImm, srcBBranchOffset} aluSrcBT;

    // One word of datapath controls, rebuilt every cycle
    typedef struct packed {
        logic        pcWrite;
        pcSourceT    pcSource;
        logic        irWrite;
        logic        regWrite;
        regDstT      regDst;
        writeSourceT writeSource;
        aluSrcAT     aluSrcA;
        aluSrcBT     aluSrcB;
        aluOpT       aluOp;
        logic        memRequest;
        logic        memWrite;
        logic        memUsesAlu;
    } controlWordT;

    // Wishbone classic, master to slave
    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [`DATA_WIDTH-1:0] adr;
        logic [`DATA_WIDTH-1:0] dat;
    } wbRequestT;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] dat;
        logic                   ack;
    } wbResponseT;

endpackage

`default_nettype wire

//--- isaPkg.sv
`default_nettype none

package isaPkg;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        opRType = 6'h00,
        opJ     = 6'h02,
        opJal   = 6'h03,
        opBeq   = 6'h04,
        opBne   = 6'h05,
        opAddi  = 6'h08,
        opAddiu = 6'h09,
        opSlti  = 6'h0a,
        opLw    = 6'h23,
        opSw    = 6'h2b
    } opcodeT;

    // Funct codes for R-type
    typedef enum logic [5:0] {
        fnJr  = 6'h08,
        fnAdd = 6'h20,
        fnSub = 6'h22,
        fnAnd = 6'h24,
        fnSlt = 6'h2a
    } functT;

    typedef struct packed {
        logic [4:0] rd;
        logic [4:0] shamt;
        functT      funct;
    } rFieldsT;

    // Low half is either rd/shamt/funct or the 16-bit immediate
    typedef union packed {
        rFieldsT     r;
        logic [15:0] imm;
    } lowHalfT;

    typedef struct packed {
        logic [4:0] rs;
        logic [4:0] rt;
        lowHalfT    low;
    } regFieldsT;

    // J-type target overlays everything below the opcode
    typedef union packed {
        regFieldsT   f;
        logic [25:0] target;
    } bodyT;

    typedef struct packed {
        opcodeT opcode;
        bodyT   body;
    } instrT;

endpackage

`default_nettype wire

//--- mipsCore_params.svh
`ifndef MIPS_CORE_PARAMS_SVH
`define MIPS_CORE_PARAMS_SVH

// Datapath geometry
`define DATA_WIDTH 32
`define REG_COUNT 32
`define REG_ADDR_WIDTH 5

// Return address register for jal
`define LINK_REG 31

// First fetch after reset
`define RESET_PC 32'h0000_0000

// Exception handlers, one per cause
`define OVERFLOW_VECTOR 32'h0000_0100
`define OPCODE_VECTOR 32'h0000_0180

`endif
